// File: src/bbox_geom_pkg.sv
// Geometry types for the bounding-box stage of the rasterizer
// Signed fixed-point coordinates, vertices, triangles and boxes
// Modules use these by scoped names

package bbox_geom_pkg;

    // Total coordinate width in bits
    localparam int coord_w = 24;
    // Fraction bits, the rest is the signed integer part
    localparam int radix = 10;

    // Signed fixed-point coordinate
    typedef logic signed [coord_w-1:0] coord_t;

    // One vertex, x in the upper half
    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // Triangle as three vertices, v0 in the top bits
    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } tri_t;

    // Axis-aligned box, lower-left corner then upper-right corner
    typedef struct packed {
        coord_t ll_x;
        coord_t ll_y;
        coord_t ur_x;
        coord_t ur_y;
    } box_t;

endpackage

// File: src/bbox_cfg_pkg.sv
// Configuration types for the bounding-box stage
// MSAA sample modes, screen size and pipeline depth

package bbox_cfg_pkg;

    // One-hot sample mode
    typedef logic [3:0] msaa_t;

    // 1x keeps no fraction bits of the box corners
    localparam msaa_t msaa_1x = 4'b1000;
    // 4x keeps one fraction bit, half a pixel per sample
    localparam msaa_t msaa_4x = 4'b0100;
    // 16x keeps two, a quarter pixel per sample
    localparam msaa_t msaa_16x = 4'b0010;
    // 64x keeps three, an eighth of a pixel
    localparam msaa_t msaa_64x = 4'b0001;

    // Screen size in the same fixed-point format as the vertices
    typedef struct packed {
        bbox_geom_pkg::coord_t width;
        bbox_geom_pkg::coord_t height;
    } screen_t;

    // Register stages between input and output
    localparam int pipe_depth = 3;

endpackage

// File: src/bbox_extent.sv
// Raw bounding box of a triangle from per-axis minima and maxima
// Purely combinational, clk only samples the assertions

`timescale 1ns/100ps

module bbox_extent (
    input  logic                clk,
    input  bbox_geom_pkg::tri_t tri_in,
    output bbox_geom_pkg::box_t raw_box
);

    // Coordinates regrouped per axis, axis 0 is x and axis 1 is y
    bbox_geom_pkg::coord_t crd [2][3];
    // One-hot vertex selects per axis
    logic [2:0] min_sel [2];
    logic [2:0] max_sel [2];
    // Selected extremes per axis
    bbox_geom_pkg::coord_t lo [2];
    bbox_geom_pkg::coord_t hi [2];

    always_comb begin
        crd[0][0] = tri_in.v0.x;
        crd[0][1] = tri_in.v1.x;
        crd[0][2] = tri_in.v2.x;
        crd[1][0] = tri_in.v0.y;
        crd[1][1] = tri_in.v1.y;
        crd[1][2] = tri_in.v2.y;
        for (int a = 0; a < 2; a++) begin
            // Minimum, ties resolve to the lower vertex index
            min_sel[a][0] = (crd[a][0] <= crd[a][1]) && (crd[a][0] <= crd[a][2]);
            min_sel[a][1] = (crd[a][0] > crd[a][1]) && (crd[a][1] <= crd[a][2]);
            min_sel[a][2] = (crd[a][0] > crd[a][2]) && (crd[a][1] > crd[a][2]);
            // Maximum, same tie rule
            max_sel[a][0] = (crd[a][0] >= crd[a][1]) && (crd[a][0] >= crd[a][2]);
            max_sel[a][1] = (crd[a][0] < crd[a][1]) && (crd[a][1] >= crd[a][2]);
            max_sel[a][2] = (crd[a][0] < crd[a][2]) && (crd[a][1] < crd[a][2]);
            // AND-OR mux driven by the one-hot selects
            lo[a] = '0;
            hi[a] = '0;
            for (int v = 0; v < 3; v++) begin
                lo[a] = lo[a] | (crd[a][v] & {bbox_geom_pkg::coord_w{min_sel[a][v]}});
                hi[a] = hi[a] | (crd[a][v] & {bbox_geom_pkg::coord_w{max_sel[a][v]}});
            end
        end
        raw_box.ll_x = lo[0];
        raw_box.ll_y = lo[1];
        raw_box.ur_x = hi[0];
        raw_box.ur_y = hi[1];
    end

    for (genvar a = 0; a < 2; a++) begin : g_axis_chk
        // Exactly one vertex wins each extreme
        assert property (@(posedge clk) $onehot(min_sel[a]) && $onehot(max_sel[a]));
        // Lower-left never above upper-right
        assert property (@(posedge clk) lo[a] <= hi[a]);
    end

endmodule

// File: src/bbox_snap_clip.sv
// Snaps a raw box to the MSAA sample grid and clips it to the screen
// Keep flags a valid triangle whose box is at least partly on screen
// Combinational, clk only samples the assertions

`timescale 1ns/100ps

module bbox_snap_clip (
    input  logic                  clk,
    input  bbox_geom_pkg::box_t   raw_box,
    input  bbox_cfg_pkg::msaa_t   msaa,
    input  bbox_cfg_pkg::screen_t screen,
    input  logic                  tri_valid,
    output bbox_geom_pkg::box_t   clip_box,
    output logic                  keep
);

    // Size of one sample step in fixed point
    bbox_geom_pkg::coord_t step;
    // Clears the fraction bits below the sample grid
    bbox_geom_pkg::coord_t mask;
    // Corners in order ll_x, ll_y, ur_x, ur_y
    bbox_geom_pkg::coord_t raw_c [4];
    bbox_geom_pkg::coord_t snap_c [4];

    // Sample step from the mode, unknown modes fall back to 1x
    always_comb begin
        step = '0;
        case (msaa)
            bbox_cfg_pkg::msaa_4x:  step[bbox_geom_pkg::radix - 1] = 1'b1;
            bbox_cfg_pkg::msaa_16x: step[bbox_geom_pkg::radix - 2] = 1'b1;
            bbox_cfg_pkg::msaa_64x: step[bbox_geom_pkg::radix - 3] = 1'b1;
            default:                step[bbox_geom_pkg::radix] = 1'b1;
        endcase
        // Integer bits stay set, so only fractions get cleared
        mask = ~(step - bbox_geom_pkg::coord_t'(1));
    end

    always_comb begin
        raw_c[0] = raw_box.ll_x;
        raw_c[1] = raw_box.ll_y;
        raw_c[2] = raw_box.ur_x;
        raw_c[3] = raw_box.ur_y;
        // Floor toward minus infinity on the sample grid
        for (int i = 0; i < 4; i++) begin
            snap_c[i] = raw_c[i] & mask;
        end
    end

    always_comb begin
        // Lower-left clamps at the origin
        clip_box.ll_x = (snap_c[0] < 0) ? '0 : snap_c[0];
        clip_box.ll_y = (snap_c[1] < 0) ? '0 : snap_c[1];
        // Upper-right clamps at the screen size
        clip_box.ur_x = (snap_c[2] > screen.width) ? screen.width : snap_c[2];
        clip_box.ur_y = (snap_c[3] > screen.height) ? screen.height : snap_c[3];
        // Reject boxes left of, below, right of or above the screen
        keep = tri_valid
            && (clip_box.ur_x >= 0) && (clip_box.ur_y >= 0)
            && (clip_box.ll_x <= screen.width) && (clip_box.ll_y <= screen.height);
    end

    // Mode must be one-hot for the step to mean anything
    assert property (@(posedge clk) $onehot(msaa));

    // A kept box stays inside the screen and is never inverted
    assert property (@(posedge clk)
        keep |-> (clip_box.ll_x <= clip_box.ur_x) && (clip_box.ur_x <= screen.width)
            && (clip_box.ll_y <= clip_box.ur_y) && (clip_box.ur_y <= screen.height));

    for (genvar i = 0; i < 4; i++) begin : g_floor_chk
        // Floor moves down by less than one sample step
        assert property (@(posedge clk)
            ((raw_c[i] - snap_c[i]) >= 0) && ((raw_c[i] - snap_c[i]) < step));
    end

endmodule

// File: src/bbox_pipe.sv
// Haltable register pipeline for triangle, box and valid
// All stages advance together while halt_n is high, otherwise everything holds

`timescale 1ns/100ps

module bbox_pipe (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                halt_n,
    input  bbox_geom_pkg::tri_t tri_in,
    input  bbox_geom_pkg::box_t box_in,
    input  logic                valid_in,
    output bbox_geom_pkg::tri_t tri_out,
    output bbox_geom_pkg::box_t box_out,
    output logic                valid_out
);

    // Stage 0 is nearest the input
    bbox_geom_pkg::tri_t tri_q [bbox_cfg_pkg::pipe_depth];
    bbox_geom_pkg::box_t box_q [bbox_cfg_pkg::pipe_depth];
    logic [bbox_cfg_pkg::pipe_depth-1:0] valid_q;

    // Payload shift
    always_ff @(posedge clk) begin
        if (halt_n) begin
            tri_q[0] <= tri_in;
            box_q[0] <= box_in;
            for (int i = 1; i < bbox_cfg_pkg::pipe_depth; i++) begin
                tri_q[i] <= tri_q[i-1];
                box_q[i] <= box_q[i-1];
            end
        end
    end

    // Valid bits clear on reset so stale payload never shows
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (halt_n) begin
            valid_q <= {valid_q[bbox_cfg_pkg::pipe_depth-2:0], valid_in};
        end
    end

    assign tri_out   = tri_q[bbox_cfg_pkg::pipe_depth-1];
    assign box_out   = box_q[bbox_cfg_pkg::pipe_depth-1];
    assign valid_out = valid_q[bbox_cfg_pkg::pipe_depth-1];

    // A box leaving the stage is never inverted
    assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> (box_out.ll_x <= box_out.ur_x) && (box_out.ll_y <= box_out.ur_y));

endmodule

// File: src/raster_bbox.sv
// Top of the bounding-box stage
// Triangle in, clipped sample-grid box out three cycles later
// halt_n low freezes the pipeline with its contents

`timescale 1ns/100ps

module raster_bbox (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  halt_n,
    input  bbox_geom_pkg::tri_t   tri_in,
    input  logic                  tri_valid,
    input  bbox_cfg_pkg::screen_t screen,
    input  bbox_cfg_pkg::msaa_t   msaa,
    output bbox_geom_pkg::tri_t   tri_out,
    output bbox_geom_pkg::box_t   box_out,
    output logic                  box_valid
);

    // Unsnapped extent of the incoming triangle
    bbox_geom_pkg::box_t raw_box;
    // Snapped and clipped box
    bbox_geom_pkg::box_t clip_box;
    // Valid and on screen
    logic keep;

    bbox_extent extent_i (
        .clk     (clk),
        .tri_in  (tri_in),
        .raw_box (raw_box)
    );

    bbox_snap_clip snap_clip_i (
        .clk       (clk),
        .raw_box   (raw_box),
        .msaa      (msaa),
        .screen    (screen),
        .tri_valid (tri_valid),
        .clip_box  (clip_box),
        .keep      (keep)
    );

    bbox_pipe pipe_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt_n    (halt_n),
        .tri_in    (tri_in),
        .box_in    (clip_box),
        .valid_in  (keep),
        .tri_out   (tri_out),
        .box_out   (box_out),
        .valid_out (box_valid)
    );

endmodule

// File: dv/bbox_clk_gen.sv
// Clock and reset for the bounding-box testbench
// 40 ns clock, rst_n low for the first two rising edges

`timescale 1ns/100ps

module bbox_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period = 20;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Release shortly after the second edge, away from the next one
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// File: dv/raster_bbox_tb.sv
// Table-driven testbench for raster_bbox
// Hand rows plus seeded random rows stream through, with two halt windows
// A three-slot model of the pipeline predicts every output cycle

`timescale 1ns/100ps

module raster_bbox_tb;

    localparam int n_hand = 14;
    localparam int n_rand = 24;
    localparam int halt_total = 6;
    localparam int depth = bbox_cfg_pkg::pipe_depth;
    // Reset, rows, pipeline fill, halts and a margin
    localparam int cycle_limit = 2 + n_hand + n_rand + depth + halt_total + 20;
    localparam bbox_cfg_pkg::msaa_t m1 = bbox_cfg_pkg::msaa_1x;
    localparam bbox_cfg_pkg::msaa_t m4 = bbox_cfg_pkg::msaa_4x;
    localparam bbox_cfg_pkg::msaa_t m16 = bbox_cfg_pkg::msaa_16x;
    localparam bbox_cfg_pkg::msaa_t m64 = bbox_cfg_pkg::msaa_64x;

    // One stimulus row with its expected result
    typedef struct packed {
        int                    id;
        bbox_geom_pkg::tri_t   tri_v;
        logic                  valid;
        bbox_cfg_pkg::msaa_t   mode;
        bbox_cfg_pkg::screen_t scr;
        bbox_geom_pkg::box_t   box;
        logic                  keep;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic                  halt_n;
    logic                  tri_valid;
    logic                  box_valid;
    bbox_geom_pkg::tri_t   tri_in;
    bbox_geom_pkg::tri_t   tri_out;
    bbox_geom_pkg::box_t   box_out;
    bbox_cfg_pkg::screen_t screen;
    bbox_cfg_pkg::msaa_t   msaa;

    row_t rows[$];
    // Model slots, the last one faces the outputs
    row_t slot [depth];
    logic slot_full [depth];
    row_t cur;
    logic cur_full;
    logic cur_halt_n;
    bbox_cfg_pkg::screen_t scr_def;
    int seed = 97519;
    int cycles = 0;

    bbox_clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    raster_bbox dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt_n    (halt_n),
        .tri_in    (tri_in),
        .tri_valid (tri_valid),
        .screen    (screen),
        .msaa      (msaa),
        .tri_out   (tri_out),
        .box_out   (box_out),
        .box_valid (box_valid)
    );

    // Coordinate from a count of eighth pixels
    function automatic bbox_geom_pkg::coord_t fx(input int e);
        return bbox_geom_pkg::coord_t'(e * (1 << (bbox_geom_pkg::radix - 3)));
    endfunction

    function automatic bbox_geom_pkg::tri_t make_tri(input int x0, y0, x1, y1, x2, y2);
        bbox_geom_pkg::tri_t t;
        t.v0.x = fx(x0);
        t.v0.y = fx(y0);
        t.v1.x = fx(x1);
        t.v1.y = fx(y1);
        t.v2.x = fx(x2);
        t.v2.y = fx(y2);
        return t;
    endfunction

    // Reference rule: extremes, floor by shifting, clamp, then reject
    function automatic void compute_expected(input bbox_geom_pkg::tri_t t, input logic v,
        input bbox_cfg_pkg::msaa_t m, input bbox_cfg_pkg::screen_t s,
        output bbox_geom_pkg::box_t b, output logic k);
        bbox_geom_pkg::coord_t xs [3];
        bbox_geom_pkg::coord_t ys [3];
        bbox_geom_pkg::coord_t zero;
        int sh;
        zero = '0;
        xs = '{t.v0.x, t.v1.x, t.v2.x};
        ys = '{t.v0.y, t.v1.y, t.v2.y};
        b = {xs[0], ys[0], xs[0], ys[0]};
        for (int i = 1; i < 3; i++) begin
            if (xs[i] < b.ll_x) b.ll_x = xs[i];
            if (ys[i] < b.ll_y) b.ll_y = ys[i];
            if (xs[i] > b.ur_x) b.ur_x = xs[i];
            if (ys[i] > b.ur_y) b.ur_y = ys[i];
        end
        case (m)
            m4:      sh = bbox_geom_pkg::radix - 1;
            m16:     sh = bbox_geom_pkg::radix - 2;
            m64:     sh = bbox_geom_pkg::radix - 3;
            default: sh = bbox_geom_pkg::radix;
        endcase
        b.ll_x = (b.ll_x >>> sh) <<< sh;
        b.ll_y = (b.ll_y >>> sh) <<< sh;
        b.ur_x = (b.ur_x >>> sh) <<< sh;
        b.ur_y = (b.ur_y >>> sh) <<< sh;
        if (b.ll_x < zero) b.ll_x = zero;
        if (b.ll_y < zero) b.ll_y = zero;
        if (b.ur_x > s.width) b.ur_x = s.width;
        if (b.ur_y > s.height) b.ur_y = s.height;
        k = v && (b.ur_x >= zero) && (b.ur_y >= zero)
            && (b.ll_x <= s.width) && (b.ll_y <= s.height);
    endfunction

    // Roughly -64 to 128 pixels, so many rows fall off screen
    function automatic bbox_geom_pkg::coord_t rand_coord();
        int r;
        r = $random(seed) % 98304;
        return bbox_geom_pkg::coord_t'(r + 32768);
    endfunction

    // Hand row, all values in eighth pixels
    task automatic add_hand(input bbox_cfg_pkg::msaa_t m, input logic v,
        input int x0, y0, x1, y1, x2, y2, input int lx, ly, ux, uy, input logic k);
        row_t w;
        w.id = rows.size();
        w.tri_v = make_tri(x0, y0, x1, y1, x2, y2);
        w.valid = v;
        w.mode = m;
        w.scr = scr_def;
        w.box = {fx(lx), fx(ly), fx(ux), fx(uy)};
        w.keep = k;
        rows.push_back(w);
    endtask

    task automatic add_random();
        row_t w;
        w.id = rows.size();
        w.tri_v.v0 = {rand_coord(), rand_coord()};
        w.tri_v.v1 = {rand_coord(), rand_coord()};
        w.tri_v.v2 = {rand_coord(), rand_coord()};
        w.mode = bbox_cfg_pkg::msaa_t'(4'b1000 >> ($random(seed) & 3));
        w.valid = (($random(seed) & 7) != 0);
        w.scr = scr_def;
        compute_expected(w.tri_v, w.valid, w.mode, w.scr, w.box, w.keep);
        rows.push_back(w);
    endtask

    task automatic check_value(input string name, input logic [143:0] exp,
        input logic [143:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("sim failed");
            $fatal(1, "mismatch");
        end
    endtask

    // Advance the model like the DUT did at the last edge, then compare
    task automatic step_and_check();
        if (cur_halt_n) begin
            for (int i = depth - 1; i > 0; i--) begin
                slot[i] = slot[i-1];
                slot_full[i] = slot_full[i-1];
            end
            slot[0] = cur;
            slot_full[0] = cur_full;
        end
        check_value($sformatf("row %0d box_valid", slot[depth-1].id),
            144'(slot[depth-1].keep), 144'(box_valid));
        if (slot_full[depth-1]) begin
            check_value($sformatf("row %0d tri_out", slot[depth-1].id),
                144'(slot[depth-1].tri_v), 144'(tri_out));
            if (slot[depth-1].keep) begin
                check_value($sformatf("row %0d box_out", slot[depth-1].id),
                    144'(slot[depth-1].box), 144'(box_out));
            end
        end
    endtask

    // Halt windows start just before these rows
    function automatic int halt_len(input int r);
        if (r == 10) return 4;
        if (r == 20) return 2;
        return 0;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int r;
        int halt_left;
        int halt_row;
        int drain;
        // 64 x 48 pixel screen
        scr_def.width = fx(512);
        scr_def.height = fx(384);
        halt_n = 1'b1;
        tri_valid = 1'b0;
        tri_in = '0;
        screen = scr_def;
        msaa = m1;
        cur = '0;
        cur_full = 1'b0;
        cur_halt_n = 1'b1;
        for (int i = 0; i < depth; i++) begin
            slot[i] = '0;
            slot_full[i] = 1'b0;
        end
        // Same triangle in every mode
        add_hand(m1, 1, 28, 18, 81, 63, 48, 13, 24, 8, 80, 56, 1);
        add_hand(m4, 1, 28, 18, 81, 63, 48, 13, 28, 12, 80, 60, 1);
        add_hand(m16, 1, 28, 18, 81, 63, 48, 13, 28, 12, 80, 62, 1);
        add_hand(m64, 1, 28, 18, 81, 63, 48, 13, 28, 13, 81, 63, 1);
        // Ties, then a degenerate point
        add_hand(m1, 1, 40, 40, 40, 75, 102, 40, 40, 40, 96, 72, 1);
        add_hand(m4, 1, 163, 245, 163, 245, 163, 245, 160, 244, 160, 244, 1);
        // Crossing the origin, then the far corner
        add_hand(m1, 1, -20, 32, 66, -24, 8, 52, 0, 0, 64, 48, 1);
        add_hand(m16, 1, 481, 320, 564, 406, 400, 363, 400, 320, 512, 384, 1);
        // Wholly left, below, right, above
        add_hand(m1, 1, -80, 40, -36, 64, -56, 16, 0, 0, 0, 0, 0);
        add_hand(m1, 1, 24, -16, 40, -48, 72, -12, 0, 0, 0, 0, 0);
        add_hand(m1, 1, 520, 80, 560, 96, 528, 160, 0, 0, 0, 0, 0);
        add_hand(m1, 1, 40, 392, 64, 440, 16, 480, 0, 0, 0, 0, 0);
        // On screen but not valid
        add_hand(m1, 0, 28, 18, 81, 63, 48, 13, 0, 0, 0, 0, 0);
        // ll exactly on the right edge
        add_hand(m1, 1, 512, 80, 516, 96, 528, 88, 512, 80, 512, 96, 1);
        for (int k = 0; k < n_rand; k++) begin
            add_random();
        end

        wait (rst_n === 1'b1);
        check_value("reset box_valid", 144'(1'b0), 144'(box_valid));
        r = 0;
        halt_left = 0;
        halt_row = -1;
        drain = 0;
        while (drain <= depth) begin
            if (halt_left == 0 && r != halt_row) begin
                halt_left = halt_len(r);
                halt_row = r;
            end
            if (halt_left > 0) begin
                // Input while halted must be ignored
                halt_n = 1'b0;
                tri_in = make_tri(8, 8, 16, 8, 8, 16);
                tri_valid = 1'b1;
                cur_halt_n = 1'b0;
                halt_left--;
            end else if (r < rows.size()) begin
                halt_n = 1'b1;
                tri_in = rows[r].tri_v;
                tri_valid = rows[r].valid;
                msaa = rows[r].mode;
                screen = rows[r].scr;
                cur = rows[r];
                cur_full = 1'b1;
                cur_halt_n = 1'b1;
                r++;
            end else begin
                halt_n = 1'b1;
                tri_valid = 1'b0;
                cur = '0;
                cur.id = -1;
                cur_full = 1'b0;
                cur_halt_n = 1'b1;
                drain++;
            end
            @(posedge clk);
            #2;
            step_and_check();
        end
        $display("sim passed");
        $finish;
    end

endmodule

// File: raster_bbox.f
src/bbox_geom_pkg.sv
src/bbox_cfg_pkg.sv
src/bbox_extent.sv
src/bbox_snap_clip.sv
src/bbox_pipe.sv
src/raster_bbox.sv
dv/bbox_clk_gen.sv
dv/raster_bbox_tb.sv

// File: Makefile
# Verilator build and run of the bounding-box stage testbench

VERILATOR ?= verilator
TOP       ?= raster_bbox_tb
FILELIST  ?= raster_bbox.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)" || { echo "test target: run did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)
